// ==== include/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// byte address split: tag | index | offset
`define ICACHE_TAG_W    23
`define ICACHE_INDEX_W  6
`define ICACHE_OFFSET_W 3

// geometry
`define ICACHE_SETS     64
`define ICACHE_WAYS     2

// one line holds two 32-bit words
`define ICACHE_LINE_W   64

`endif

// ==== hdl/icache_pkg.sv ====
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

    // fetch address, seen flat on the memory side and split by the stages
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [`ICACHE_TAG_W-1:0]    tag;
            logic [`ICACHE_INDEX_W-1:0]  index;
            logic [`ICACHE_OFFSET_W-1:0] offset;
        } f;
    } icache_addr_u;

endpackage

`default_nettype wire

// ==== hdl/icache_req_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module icache_req_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    input  icache_pkg::icache_addr_u addr,
    input  logic                   stall,
    output logic                   addr_ok,
    output logic                   req_valid,
    output icache_pkg::icache_addr_u req_addr
);

    logic take;

    // a request is taken only while the pipeline moves
    assign addr_ok = ~stall;
    assign take    = valid & ~stall;

    // entry stays put under stall so the missed request can replay
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (!stall) begin
            req_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_addr <= addr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_tag_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "icache_consts.svh"

module icache_tag_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    input  icache_pkg::icache_addr_u   req_addr,
    input  logic                       fill_we,
    input  logic                       fill_way,
    input  logic [`ICACHE_INDEX_W-1:0] fill_index,
    input  logic [`ICACHE_TAG_W-1:0]   fill_tag,
    input  logic                       fill_done,
    output logic                       stall,
    output logic                       lkp_valid,
    output logic                       lkp_hit_way,
    output icache_pkg::icache_addr_u   lkp_addr,
    output logic                       miss,
    output icache_pkg::icache_addr_u   miss_addr,
    output logic                       victim_way
);

    import icache_pkg::*;

    logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;

    logic [`ICACHE_WAYS-1:0] way_valid;
    logic [`ICACHE_WAYS-1:0] way_hit;
    logic                    hit;
    logic                    pend;
    logic                    active;
    logic                    rand_bit;

    // per-way compare against the held request
    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        assign way_valid[w] = valid_q[w][req_addr.f.index];
        assign way_hit[w]   = way_valid[w] &&
                              (tag_mem[w][req_addr.f.index] == req_addr.f.tag);
    end

    assign hit = |way_hit;

    // lookup is blocked while a refill is out, replayed on fill_done
    assign active = ~pend | fill_done;

    assign lkp_valid   = req_valid & active & hit;
    assign lkp_hit_way = way_hit[1];
    assign lkp_addr    = req_addr;

    assign miss      = req_valid & active & ~hit;
    assign miss_addr = req_addr;
    assign stall     = miss | (pend & ~fill_done);

    // invalid way first, otherwise the toggle
    assign victim_way = !way_valid[0] ? 1'b0 :
                        !way_valid[1] ? 1'b1 : rand_bit;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else if (miss) begin
            pend <= 1'b1;
        end else if (fill_done) begin
            pend <= 1'b0;
        end
    end

    // free-running, advances every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rand_bit <= 1'b0;
        end else begin
            rand_bit <= ~rand_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_we) begin
            valid_q[fill_way][fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[fill_way][fill_index] <= fill_tag;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_data_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "icache_consts.svh"

module icache_data_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       lkp_valid,
    input  logic                       lkp_hit_way,
    input  logic [31:0]                lkp_addr,
    input  logic                       fill_we,
    input  logic                       fill_way,
    input  logic [`ICACHE_INDEX_W-1:0] fill_index,
    input  logic [`ICACHE_LINE_W-1:0]  fill_line,
    output logic                       data_ok,
    output logic [31:0]                rdata
);

    logic [`ICACHE_LINE_W-1:0]  line_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_INDEX_W-1:0] lkp_index;
    logic [`ICACHE_LINE_W-1:0]  line_q;
    logic                       word_sel_q;

    assign lkp_index = lkp_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    // refill writes a whole line at once
    always_ff @(posedge clk) begin
        if (fill_we) begin
            line_mem[fill_way][fill_index] <= fill_line;
        end
    end

    // synchronous line read on a hit
    always_ff @(posedge clk) begin
        if (lkp_valid) begin
            line_q     <= line_mem[lkp_hit_way][lkp_index];
            word_sel_q <= lkp_addr[`ICACHE_OFFSET_W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= lkp_valid;
        end
    end

    // offset bit 2 picks the upper word
    assign rdata = word_sel_q ? line_q[`ICACHE_LINE_W-1 -: 32] : line_q[31:0];

endmodule

`default_nettype wire

// ==== hdl/icache_refill.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "icache_consts.svh"

module icache_refill (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       miss,
    input  icache_pkg::icache_addr_u   miss_addr,
    input  logic                       victim_way,
    input  logic                       ret_valid,
    input  logic [`ICACHE_LINE_W-1:0]  ret_data,
    output logic                       rd_req,
    output logic [31:0]                rd_addr,
    output logic                       fill_we,
    output logic                       fill_way,
    output logic [`ICACHE_INDEX_W-1:0] fill_index,
    output logic [`ICACHE_TAG_W-1:0]   fill_tag,
    output logic [`ICACHE_LINE_W-1:0]  fill_line,
    output logic                       fill_done
);

    import icache_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WAIT  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;

    logic [1:0]                state;
    icache_addr_u              line_addr;
    logic                      victim_q;
    logic [`ICACHE_LINE_W-1:0] line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            rd_req    <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            rd_req    <= 1'b0;
            fill_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (miss) begin
                        state  <= ST_WAIT;
                        rd_req <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (ret_valid) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    state     <= ST_IDLE;
                    fill_done <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // miss buffer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && miss) begin
            line_addr <= miss_addr;
            victim_q  <= victim_way;
        end
        if (state == ST_WAIT && ret_valid) begin
            line_q <= ret_data;
        end
    end

    assign rd_addr = {line_addr.word[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    // single write cycle into tag and data arrays
    assign fill_we    = (state == ST_WRITE);
    assign fill_way   = victim_q;
    assign fill_index = line_addr.f.index;
    assign fill_tag   = line_addr.f.tag;
    assign fill_line  = line_q;

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "icache_consts.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,
    // fetch side
    input  logic                      valid,
    input  logic [31:0]               addr,
    output logic                      addr_ok,
    output logic                      data_ok,
    output logic [31:0]               rdata,
    // memory side
    output logic                      rd_req,
    output logic [31:0]               rd_addr,
    input  logic                      ret_valid,
    input  logic [`ICACHE_LINE_W-1:0] ret_data
);

    import icache_pkg::*;

    logic                       stall;
    logic                       req_valid;
    icache_addr_u               req_addr;
    logic                       lkp_valid;
    logic                       lkp_hit_way;
    icache_addr_u               lkp_addr;
    logic                       miss;
    icache_addr_u               miss_addr;
    logic                       victim_way;
    logic                       fill_we;
    logic                       fill_way;
    logic [`ICACHE_INDEX_W-1:0] fill_index;
    logic [`ICACHE_TAG_W-1:0]   fill_tag;
    logic [`ICACHE_LINE_W-1:0]  fill_line;
    logic                       fill_done;

    icache_req_stage u_req (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .addr      (addr),
        .stall     (stall),
        .addr_ok   (addr_ok),
        .req_valid (req_valid),
        .req_addr  (req_addr)
    );

    icache_tag_stage u_tag (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .fill_we     (fill_we),
        .fill_way    (fill_way),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag),
        .fill_done   (fill_done),
        .stall       (stall),
        .lkp_valid   (lkp_valid),
        .lkp_hit_way (lkp_hit_way),
        .lkp_addr    (lkp_addr),
        .miss        (miss),
        .miss_addr   (miss_addr),
        .victim_way  (victim_way)
    );

    icache_data_stage u_data (
        .clk         (clk),
        .rst         (rst),
        .lkp_valid   (lkp_valid),
        .lkp_hit_way (lkp_hit_way),
        .lkp_addr    (lkp_addr.word),
        .fill_we     (fill_we),
        .fill_way    (fill_way),
        .fill_index  (fill_index),
        .fill_line   (fill_line),
        .data_ok     (data_ok),
        .rdata       (rdata)
    );

    icache_refill u_refill (
        .clk        (clk),
        .rst        (rst),
        .miss       (miss),
        .miss_addr  (miss_addr),
        .victim_way (victim_way),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .fill_we    (fill_we),
        .fill_way   (fill_way),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .fill_done  (fill_done)
    );

endmodule

`default_nettype wire

// ==== tb/icache_chk.sv ====
`default_nettype none
`timescale 1ns/10ps

module icache_chk (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid,
    input  icache_pkg::icache_addr_u addr,
    input  logic                     addr_ok,
    input  logic                     data_ok,
    input  logic [31:0]              rdata,
    input  logic                     rd_req,
    input  icache_pkg::icache_addr_u rd_addr
);

    import icache_pkg::*;

    // taken fetch addresses, oldest at head
    icache_addr_u pend_q [8];
    logic [2:0]   head;
    logic [2:0]   tail;
    logic         seen_req;
    logic         take;
    logic [31:0]  exp_word;
    int unsigned  fails = 0;

    assign take     = valid & addr_ok;
    assign exp_word = {pend_q[head].word[31:2], 2'b00} ^ 32'h5a5a_0000;

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            seen_req <= 1'b0;
        end else begin
            if (take) begin
                pend_q[tail] <= addr;
                tail         <= tail + 3'd1;
                seen_req     <= 1'b1;
            end
            if (data_ok) begin
                head <= head + 3'd1;
            end
        end
    end

    rdata_matches: assert property (@(posedge clk) disable iff (rst)
        data_ok |-> (head != tail && rdata == exp_word))
        else begin
            fails++;
            $error("** Error at %0t: rdata %h, expected %h", $time, rdata, exp_word);
        end

    no_read_while_open: assert property (@(posedge clk) disable iff (rst)
        rd_req |-> !addr_ok)
        else begin
            fails++;
            $error("rd_req was high while addr_ok was high at %0t", $time);
        end

    // the read is for the line of the oldest unanswered request
    read_line_matches: assert property (@(posedge clk) disable iff (rst)
        rd_req |-> (head != tail && rd_addr.f.offset == '0 &&
                    rd_addr.f.index == pend_q[head].f.index &&
                    rd_addr.f.tag == pend_q[head].f.tag))
        else begin
            fails++;
            $error("rd_addr %h is not the aligned line of request %h at %0t",
                   rd_addr.word, pend_q[head].word, $time);
        end

    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_req |-> (!data_ok && !rd_req))
        else begin
            fails++;
            $error("response or memory read before any request was taken at %0t", $time);
        end

endmodule

`default_nettype wire

// ==== tb/icache_top_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "icache_consts.svh"

module icache_top_tb;

    logic                      clk;
    logic                      rst;
    logic                      valid;
    logic [31:0]               addr;
    logic                      addr_ok;
    logic                      data_ok;
    logic [31:0]               rdata;
    logic                      rd_req;
    logic [31:0]               rd_addr;
    logic                      ret_valid = 1'b0;
    logic [`ICACHE_LINE_W-1:0] ret_data = '0;

    int          rd_cnt = 0;
    int          ok_cnt = 0;
    int          taken_cnt = 0;
    int          err_cnt = 0;
    logic        timed_out = 1'b0;
    // forced memory delay, 0 picks one from the LCG
    int          mem_hold = 0;
    int          mem_wait = 0;
    logic        mem_busy = 1'b0;
    logic [31:0] mem_line = '0;
    logic [31:0] mem_seed = 32'hb3cd66d8;
    logic [31:0] stim_seed = 32'hb3cd66d8;

    icache_top DUT (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .addr      (addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    bind icache_top icache_chk u_chk (
        .clk     (clk),
        .rst     (rst),
        .valid   (valid),
        .addr    (addr),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata),
        .rd_req  (rd_req),
        .rd_addr (rd_addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] make_addr(input logic [22:0] tag,
                                              input logic [5:0] index,
                                              input logic word);
        return {tag, index, word, 2'b00};
    endfunction

    function automatic int fault_total();
        return err_cnt + int'(DUT.u_chk.fails);
    endfunction

    always @(negedge clk) begin
        if (rd_req) begin
            rd_cnt++;
        end
        if (data_ok) begin
            ok_cnt++;
        end
    end

    // memory answers each rd_req with the whole line
    always @(negedge clk) begin
        ret_valid = 1'b0;
        if (mem_busy) begin
            if (mem_wait == 0) begin
                ret_valid = 1'b1;
                ret_data  = {mem_word(mem_line + 32'd4), mem_word(mem_line)};
                mem_busy  = 1'b0;
            end else begin
                mem_wait--;
            end
        end else if (rd_req) begin
            mem_busy = 1'b1;
            mem_line = rd_addr;
            mem_seed = lcg_step(mem_seed);
            mem_wait = (mem_hold != 0) ? mem_hold : int'(mem_seed[18:16]);
        end
    end

    // present one request and hold it until addr_ok takes it
    task automatic fetch(input logic [31:0] a, output int waited);
        waited = 0;
        if (timed_out) return;
        @(negedge clk);
        valid = 1'b1;
        addr  = a;
        while (!addr_ok && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!addr_ok) begin
            $display("timeout: request %h was never accepted", a);
            timed_out = 1'b1;
        end else begin
            taken_cnt++;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        @(negedge clk);
        valid = 1'b0;
        if (timed_out) return;
        while (ok_cnt != taken_cnt && n < 300) begin
            @(posedge clk);
            n++;
        end
        if (ok_cnt != taken_cnt) begin
            $display("timeout: %0d requests taken but only %0d answered", taken_cnt, ok_cnt);
            timed_out = 1'b1;
        end
    endtask

    task automatic expect_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic print_result(input int num, input string name, input int faults_before);
        $display("test %0d %s: %s", num, name,
                 (fault_total() == faults_before && !timed_out) ? "ok" : "errors");
    endtask

    initial begin
        int          e0;
        int          r0;
        int          k0;
        int          t0;
        int          w;
        int          ra;
        int          rb;
        logic [31:0] r;

        rst   = 1'b1;
        valid = 1'b0;
        addr  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e0 = fault_total();
        r0 = rd_cnt;
        fetch(make_addr(23'h10, 6'd5, 1'b0), w);
        drain();
        expect_count("test 1 rd_req on cold fetch", rd_cnt - r0, 1);
        r0 = rd_cnt;
        fetch(make_addr(23'h10, 6'd5, 1'b1), w);
        drain();
        expect_count("test 1 rd_req on second word", rd_cnt - r0, 0);
        print_result(1, "cold miss then hit", e0);

        // two more resident lines, then stream over all three
        fetch(make_addr(23'h20, 6'd6, 1'b0), w);
        fetch(make_addr(23'h20, 6'd7, 1'b1), w);
        drain();
        e0 = fault_total();
        r0 = rd_cnt;
        k0 = ok_cnt;
        for (int i = 0; i < 12; i++) begin
            fetch(make_addr((i % 3 == 0) ? 23'h10 : 23'h20, 6'(5 + i % 3), i[0]), w);
        end
        drain();
        expect_count("test 2 rd_req", rd_cnt - r0, 0);
        expect_count("test 2 data_ok", ok_cnt - k0, 12);
        print_result(2, "streaming hits", e0);

        e0 = fault_total();
        fetch(make_addr(23'h31, 6'd10, 1'b0), w);
        drain();
        fetch(make_addr(23'h32, 6'd10, 1'b1), w);
        drain();
        r0 = rd_cnt;
        for (int i = 0; i < 8; i++) begin
            fetch(make_addr(i[0] ? 23'h32 : 23'h31, 6'd10, i[1]), w);
        end
        drain();
        expect_count("test 3 rd_req", rd_cnt - r0, 0);
        print_result(3, "two-way fill", e0);

        e0 = fault_total();
        r0 = rd_cnt;
        fetch(make_addr(23'h33, 6'd10, 1'b0), w);
        drain();
        expect_count("test 4 rd_req for C", rd_cnt - r0, 1);
        r0 = rd_cnt;
        fetch(make_addr(23'h31, 6'd10, 1'b0), w);
        drain();
        ra = rd_cnt - r0;
        fetch(make_addr(23'h32, 6'd10, 1'b0), w);
        drain();
        rb = rd_cnt - r0 - ra;
        // C pushed out one of A and B
        // a refill of A may in turn push out B
        expect_count("test 4 rd_req for A", (ra > 1) ? ra : 1, 1);
        expect_count("test 4 rd_req for B", (ra == 0 || rb > 1) ? rb : 1, 1);
        print_result(4, "eviction", e0);

        // miss with a slow memory, then a resident line held behind it
        e0 = fault_total();
        r0 = rd_cnt;
        k0 = ok_cnt;
        t0 = taken_cnt;
        mem_hold = 20;
        fetch(make_addr(23'h50, 6'd20, 1'b1), w);
        fetch(make_addr(23'h10, 6'd5, 1'b0), w);
        drain();
        mem_hold = 0;
        expect_count("test 5 held request waited past refill", (w >= 20) ? 1 : 0, 1);
        expect_count("test 5 rd_req", rd_cnt - r0, 1);
        expect_count("test 5 data_ok", ok_cnt - k0, taken_cnt - t0);
        print_result(5, "stall under back-pressure", e0);

        e0 = fault_total();
        k0 = ok_cnt;
        t0 = taken_cnt;
        for (int i = 0; i < 200; i++) begin
            stim_seed = lcg_step(stim_seed);
            r = stim_seed;
            fetch(make_addr(23'h60 + {21'd0, r[17:16]}, {3'd0, r[20:18]}, r[21]), w);
        end
        drain();
        expect_count("test 6 taken requests", taken_cnt - t0, 200);
        expect_count("test 6 data_ok", ok_cnt - k0, 200);
        print_result(6, "random traffic", e0);

        $display("rd_req %0d, data_ok %0d, taken %0d, errors %0d",
                 rd_cnt, ok_cnt, taken_cnt, fault_total());
        if (fault_total() == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache_top.f ====
+incdir+include
hdl/icache_pkg.sv
hdl/icache_req_stage.sv
hdl/icache_tag_stage.sv
hdl/icache_data_stage.sv
hdl/icache_refill.sv
hdl/icache_top.sv
tb/icache_chk.sv
tb/icache_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module icache_top_tb -f icache_top.f -o Vicache_top_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vicache_top_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
